// ==== ein_input.txt ====
// one frame per line, all columns hex: eid flags goc_mode clk_div length ack_eid collision
// a collision line is sent during the frame above it, keeps that frame's goc_mode and clk_div
// and names in ack_eid the eid of the acknowledge that follows it
a1 00 0 000003 04 a1 0
b2 00 1 000002 03 b2 0
c3 01 0 000001 02 c3 0 // fragment, no end mark
d4 00 1 000000 00 d4 0 // empty payload gives the end mark alone
e5 01 0 000004 00 e5 0 // empty fragment leaves the pads quiet
f6 00 0 000002 05 f6 0
17 00 0 000002 03 f6 1
28 01 1 000005 14 28 0 // twenty bytes of which sixteen go out
39 00 1 000001 10 39 0
4a 00 0 000003 02 4a 0
5b 00 0 000003 01 4a 1
6c 00 1 000000 08 6c 0

// ==== tb.f ====
ein_pkg.sv
header_decoder.sv
ein_mod.sv
ack_generator.sv
ein_int.sv
ein_int_assert.sv
tb_ein_int.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_ein_int -o tb_ein_int \
	&& ./obj_dir/tb_ein_int > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_ein_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ein_int;

	localparam int max_frames = 16;
	localparam int n_cols = 7;
	localparam int max_payload = 16;
	localparam logic [7:0] ack_code = 8'h06;

	logic reset;                      // clock
	logic clk;                        // asynchronous reset, active high
	logic goc_mode;
	logic [23:0] clk_div;
	logic [7:0] ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic overflow;
	logic emo_pad;
	logic edi_pad;
	logic eci_pad;
	logic [7:0] ack_data;
	logic ack_data_valid;
	logic ack_frame_valid;

	logic [31:0] frames [max_frames * n_cols];
	logic [2:0] exp_q [$];            // low bits hold the symbol (0 emo, 1 edi, 2 eci) and bit 2 marks a first symbol
	logic [7:0] ack_q [$];
	int exp_rd = 0;
	int ack_rd = 0;
	int ack_frame_cycles = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int last_toggle = 0;
	int overflow_seen = 0;
	logic [2:0] prev_pads = '0;
	logic first_pending;
	logic [31:0] rng = 32'd89249;

	ein_int DUT (.*);

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// bit order on the pads follows goc_mode and is lsb first when it is high
	task automatic expect_byte(input logic [7:0] b);
		logic bit_val;
		for (int k = 0; k < 8; k++) begin
			bit_val = goc_mode ? b[k] : b[7 - k];
			exp_q.push_back({first_pending, 1'b0, bit_val});
			first_pending = 1'b0;
		end
	endtask

	task automatic send_frame(input logic [7:0] eid, input logic [7:0] flags, input int len,
		input logic keep);
		logic [7:0] b;
		int gap;
		first_pending = 1'b1;
		ma_frame_valid = 1'b1;
		for (int k = 0; k < len + 2; k++) begin
			rng = xorshift32(rng);
			gap = int'(rng % 32'd3);
			repeat (gap) @(negedge reset);
			if (k == 0) begin
				b = eid;
			end else if (k == 1) begin
				b = flags;
			end else begin
				b = rng[15:8];
			end
			if (keep && k >= 2 && k < max_payload + 2) begin
				expect_byte(b);   // bytes past the sixteenth never reach the pads
			end
			ma_data = b;
			ma_data_valid = 1'b1;
			@(negedge reset);
			ma_data_valid = 1'b0;
		end
		if (keep && !flags[0]) begin
			exp_q.push_back({first_pending, 2'd2});
		end
		ma_frame_valid = 1'b0;
		@(negedge reset);
	endtask

	initial begin
		reset = 1'b0;
		forever #10 reset = ~reset;
	end

	always @(posedge reset) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			stop_run($sformatf("timeout: the run went past %0d clock cycles", cycle_limit));
		end
	end

	// pads, acknowledge bytes and overflow are stable at the falling edge
	always @(negedge reset) begin : monitor
		logic [2:0] pads;
		logic [2:0] flips;
		logic [1:0] sym;
		pads = {eci_pad, edi_pad, emo_pad};
		flips = pads ^ prev_pads;
		prev_pads = pads;
		if (!clk && flips != 3'b000) begin
			sym = flips[0] ? 2'd0 : (flips[1] ? 2'd1 : 2'd2);
			assert ($countones(flips) == 1)
				else stop_run($sformatf("error at %0d ns: pads %b toggled together", $time, flips));
			assert (exp_rd < exp_q.size())
				else stop_run($sformatf("error at %0d ns: symbol %0d with none expected", $time, sym));
			assert (exp_q[exp_rd][1:0] == sym)
				else stop_run($sformatf("error at %0d ns: symbol %0d is %0d, expected %0d",
					$time, exp_rd, sym, exp_q[exp_rd][1:0]));
			assert (exp_q[exp_rd][2] || cycle_count - last_toggle == int'(clk_div) + 1)
				else stop_run($sformatf("error at %0d ns: symbol %0d came %0d cycles after the last",
					$time, exp_rd, cycle_count - last_toggle));
			last_toggle = cycle_count;
			exp_rd++;
		end
		if (!clk && ack_frame_valid) begin
			ack_frame_cycles++;
		end
		if (!clk && ack_data_valid) begin
			ack_q.push_back(ack_data);
		end
		if (!clk && overflow) begin
			overflow_seen++;
		end
	end

	initial begin
		int n_frames;
		int n_collisions;
		int base;
		int i;
		int len;
		int symbols;
		int mark;
		int ovf_mark;
		int wait_cycles;
		logic collision;
		clk = 1'b1;
		goc_mode = 1'b0;
		clk_div = '0;
		ma_data = '0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		first_pending = 1'b1;
		foreach (frames[k]) frames[k] = '1;
		$readmemh("ein_input.txt", frames);
		n_frames = 0;
		n_collisions = 0;
		while (n_frames < max_frames && frames[n_frames * n_cols] != '1) begin
			base = n_frames * n_cols;
			len = int'(frames[base + 4]);
			symbols = (len > max_payload ? max_payload : len) * 8 + (frames[base + 1][0] ? 0 : 1);
			cycle_limit = cycle_limit + symbols * (int'(frames[base + 3][23:0]) + 1) + 200;
			if (frames[base + 6][0]) begin
				n_collisions++;
			end
			n_frames++;
		end
		assert (n_frames > 0) else stop_run("no frame could be read from ein_input.txt");
		repeat (2) @(negedge reset);
		clk = 1'b0;
		@(negedge reset);
		assert ({emo_pad, edi_pad, eci_pad, overflow, ack_data_valid, ack_frame_valid} == 6'b0)
			else stop_run($sformatf("error at %0d ns: outputs not low after reset", $time));
		i = 0;
		while (i < n_frames) begin
			base = i * n_cols;
			collision = (i + 1 < n_frames) && frames[base + n_cols + 6][0];
			assert (ack_q.size() == ack_rd)
				else stop_run($sformatf("error at %0d ns: extra acknowledge byte", $time));
			goc_mode = frames[base + 2][0];
			clk_div = frames[base + 3][23:0];
			mark = exp_rd;
			send_frame(frames[base][7:0], frames[base + 1][7:0], int'(frames[base + 4]), 1'b1);
			if (collision) begin
				while (exp_rd == mark) @(negedge reset);   // running transmission has begun
				ovf_mark = overflow_seen;
				send_frame(frames[base + n_cols][7:0], frames[base + n_cols + 1][7:0],
					int'(frames[base + n_cols + 4]), 1'b0);
				wait_cycles = 0;
				while (overflow_seen == ovf_mark && wait_cycles < 4) begin
					@(negedge reset);
					wait_cycles++;
				end
				assert (overflow_seen == ovf_mark + 1)
					else stop_run($sformatf("error at %0d ns: no overflow for frame %0d", $time, i + 1));
				base = base + n_cols;
			end
			while (ack_q.size() < ack_rd + 2) @(negedge reset);
			assert (exp_rd == exp_q.size())
				else stop_run($sformatf("error at %0d ns: %0d symbols missing before the acknowledge",
					$time, exp_q.size() - exp_rd));
			assert (ack_q[ack_rd] == ack_code)
				else stop_run($sformatf("error at %0d ns: ack byte %h, expected %h",
					$time, ack_q[ack_rd], ack_code));
			assert (ack_q[ack_rd + 1] == frames[base + 5][7:0])
				else stop_run($sformatf("error at %0d ns: ack eid %h, expected %h",
					$time, ack_q[ack_rd + 1], frames[base + 5][7:0]));
			ack_rd = ack_rd + 2;
			while (ack_frame_valid) @(negedge reset);
			@(negedge reset);
			assert (ack_frame_cycles == ack_rd)
				else stop_run($sformatf("error at %0d ns: ack_frame_valid high %0d cycles, expected %0d",
					$time, ack_frame_cycles, ack_rd));
			i += collision ? 2 : 1;
		end
		assert (ack_q.size() == ack_rd && exp_rd == exp_q.size())
			else stop_run($sformatf("error at %0d ns: activity after the last frame", $time));
		assert (overflow_seen == n_collisions)
			else stop_run($sformatf("error at %0d ns: %0d overflow pulses, expected %0d",
				$time, overflow_seen, n_collisions));
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ein_int_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ein_int_assert (
	input wire reset,
	input wire clk,
	input wire emo_pad,
	input wire edi_pad,
	input wire eci_pad,
	input wire overflow,
	input wire ack_data_valid,
	input wire ack_frame_valid
);

	// each symbol start moves exactly one wire
	one_pad_toggle: assert property (@(posedge reset) disable iff (clk)
		$countones({emo_pad ^ $past(emo_pad), edi_pad ^ $past(edi_pad),
			eci_pad ^ $past(eci_pad)}) <= 1)
		else $error("more than one pad toggled in the same cycle");

	// an acknowledge frame lasts two cycles and carries a byte in each of them
	ack_two_byte_frame: assert property (@(posedge reset) disable iff (clk)
		$fell(ack_frame_valid) |-> !ack_data_valid && $past(ack_data_valid) &&
			$past(ack_data_valid, 2) && $past(ack_frame_valid, 2) &&
			!$past(ack_frame_valid, 3))
		else $error("ack frame was not two cycles long with a valid byte in each");

	overflow_pulse: assert property (@(posedge reset) disable iff (clk)
		overflow |=> !overflow)
		else $error("overflow stayed high for more than one cycle");

endmodule

bind ein_int ein_int_assert u_ein_int_assert (
	.reset(reset),
	.clk(clk),
	.emo_pad(emo_pad),
	.edi_pad(edi_pad),
	.eci_pad(eci_pad),
	.overflow(overflow),
	.ack_data_valid(ack_data_valid),
	.ack_frame_valid(ack_frame_valid)
);

`default_nettype wire

// ==== ein_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module ein_int (
	input wire reset,
	input wire clk,
	input wire goc_mode,
	input wire ein_pkg::div_t clk_div,
	input wire ein_pkg::byte_t ma_data,
	input wire ma_data_valid,
	input wire ma_frame_valid,
	output logic overflow,
	output logic emo_pad,
	output logic edi_pad,
	output logic eci_pad,
	output ein_pkg::byte_t ack_data,
	output logic ack_data_valid,
	output logic ack_frame_valid
);
	import ein_pkg::*;

	byte_t fifo_dout;
	eid_t header_eid;
	logic fifo_empty;
	logic fifo_re;
	logic is_fragment;
	logic header_done;
	logic tx_done;
	logic generate_ack;
	ctl_state_t state;
	ctl_state_t next_state;

	header_decoder hd0 (
		.reset(reset),
		.clk(clk),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.fifo_re(fifo_re),
		.tx_done(tx_done),
		.fifo_dout(fifo_dout),
		.fifo_empty(fifo_empty),
		.header_eid(header_eid),
		.is_fragment(is_fragment),
		.header_done(header_done),
		.overflow(overflow)
	);

	ein_mod pm0 (
		.reset(reset),
		.clk(clk),
		.clk_div(clk_div),
		.goc_mode(goc_mode),
		.fifo_dout(fifo_dout),
		.fifo_empty(fifo_empty),
		.is_fragment(is_fragment),
		.header_done(header_done),
		.fifo_re(fifo_re),
		.tx_done(tx_done),
		.emo_pad(emo_pad),
		.edi_pad(edi_pad),
		.eci_pad(eci_pad)
	);

	ack_generator ag0 (
		.reset(reset),
		.clk(clk),
		.generate_ack(generate_ack),
		.eid_in(header_eid),
		.ack_data(ack_data),
		.ack_data_valid(ack_data_valid),
		.ack_frame_valid(ack_frame_valid)
	);

	// the modulator does the real work, this only notices when header_done drops
	always_comb begin
		next_state = state;
		generate_ack = 1'b0;
		case (state)
		ctl_idle: begin
			if (header_done) begin
				next_state = ctl_transmitting;
			end
		end
		ctl_transmitting: begin
			if (!header_done) begin
				next_state = ctl_acknowledge;
			end
		end
		ctl_acknowledge: begin
			generate_ack = 1'b1;   // one cycle only, state leaves right away
			next_state = ctl_idle;
		end
		default: next_state = ctl_idle;
		endcase
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state <= ctl_idle;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

// ==== ack_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module ack_generator (
	input wire reset,
	input wire clk,
	input wire generate_ack,
	input wire ein_pkg::eid_t eid_in,
	output ein_pkg::byte_t ack_data,
	output logic ack_data_valid,
	output logic ack_frame_valid
);
	import ein_pkg::*;

	logic [1:0] phase;   // 0 quiet, 1 sending ack_code, 2 sending the eid
	eid_t eid_r;
	logic sending;

	always_ff @(posedge reset) begin
		if (generate_ack) begin
			eid_r <= eid_in;
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			phase <= 2'd0;
		end else begin
			if (generate_ack) begin
				phase <= 2'd1;
			end else if (phase == 2'd1) begin
				phase <= 2'd2;
			end else begin
				phase <= 2'd0;   // message is over after the eid byte
			end
		end
	end

	assign sending = (phase != 2'd0);
	assign ack_frame_valid = sending;
	assign ack_data_valid = sending;   // every cycle of the message carries a byte

	always_comb begin
		case (phase)
		2'd1: ack_data = ack_code;
		2'd2: ack_data = eid_r;
		default: ack_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== ein_mod.sv ====
`timescale 1ns/1ps
`default_nettype none

module ein_mod (
	input wire reset,
	input wire clk,
	input wire ein_pkg::div_t clk_div,
	input wire goc_mode,
	input wire ein_pkg::byte_t fifo_dout,
	input wire fifo_empty,
	input wire is_fragment,
	input wire header_done,
	output logic fifo_re,
	output logic tx_done,
	output logic emo_pad,
	output logic edi_pad,
	output logic eci_pad
);
	import ein_pkg::*;

	mod_state_t state;
	div_t period_cnt;
	byte_t shreg;
	byte_t next_shreg;
	logic [2:0] bit_cnt;
	logic last_cycle;
	logic byte_end;
	logic bit_step;
	logic need_byte;
	logic start_data;
	logic start_mark;
	logic data_bit;

	function automatic logic head_bit(byte_t b, logic lsb_first);
		return lsb_first ? b[0] : b[7];
	endfunction

	assign last_cycle = (period_cnt == clk_div);
	assign byte_end = (state == mod_symbol) && last_cycle && (bit_cnt == 3'd7);
	assign bit_step = (state == mod_symbol) && last_cycle && (bit_cnt != 3'd7);
	assign need_byte = (state == mod_load) || byte_end;  // a new byte is due this cycle
	assign next_shreg = goc_mode ? {1'b0, shreg[7:1]} : {shreg[6:0], 1'b0};

	assign fifo_re = need_byte && !fifo_empty;
	assign start_data = fifo_re || bit_step;
	assign start_mark = need_byte && fifo_empty && !is_fragment;
	assign data_bit = fifo_re ? head_bit(fifo_dout, goc_mode) : head_bit(next_shreg, goc_mode);
	assign tx_done = ((state == mod_end_mark) && last_cycle) ||
		(need_byte && fifo_empty && is_fragment);     // a fragment ends without a mark

	always_ff @(posedge reset) begin
		if (fifo_re) begin
			shreg <= fifo_dout;
		end else if (bit_step) begin
			shreg <= next_shreg;
		end
	end

	// pads flip on the edge that opens a symbol, so the change shows in its first cycle
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			emo_pad <= 1'b0;
			edi_pad <= 1'b0;
			eci_pad <= 1'b0;
		end else begin
			if (start_data) begin
				if (data_bit) begin
					edi_pad <= ~edi_pad;
				end else begin
					emo_pad <= ~emo_pad;
				end
			end
			if (start_mark) begin
				eci_pad <= ~eci_pad;
			end
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state <= mod_idle;
			period_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
			mod_idle: begin
				if (header_done) begin
					state <= mod_load;
				end
			end
			mod_load, mod_symbol: begin
				if (state == mod_symbol && !last_cycle) begin
					period_cnt <= period_cnt + 1'b1;
				end else begin
					period_cnt <= '0;
					if (bit_step) begin
						bit_cnt <= bit_cnt + 1'b1;
					end else if (fifo_re) begin
						bit_cnt <= '0;
						state <= mod_symbol;   // next byte follows with no gap
					end else if (is_fragment) begin
						state <= mod_idle;
					end else begin
						state <= mod_end_mark;
					end
				end
			end
			mod_end_mark: begin
				if (last_cycle) begin
					state <= mod_idle;
				end else begin
					period_cnt <= period_cnt + 1'b1;
				end
			end
			default: state <= mod_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== header_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module header_decoder (
	input wire reset,
	input wire clk,
	input wire ein_pkg::byte_t ma_data,
	input wire ma_data_valid,
	input wire ma_frame_valid,
	input wire fifo_re,
	input wire tx_done,
	output ein_pkg::byte_t fifo_dout,
	output logic fifo_empty,
	output ein_pkg::eid_t header_eid,
	output logic is_fragment,
	output logic header_done,
	output logic overflow
);
	import ein_pkg::*;

	hd_state_t state;
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	byte_t mem [fifo_depth];
	logic wr_en;
	logic rd_en;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_dout = mem[rd_ptr[fifo_aw-1:0]];
	assign rd_en = fifo_re && !fifo_empty;
	assign wr_en = (state == hd_payload) && ma_frame_valid && ma_data_valid &&
		(wr_ptr != ptr_t'(fifo_depth));            // bytes past the sixteenth are lost

	always_ff @(posedge reset) begin
		if (wr_en) begin
			mem[wr_ptr[fifo_aw-1:0]] <= ma_data;
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state <= hd_idle;
			wr_ptr <= '0;
			rd_ptr <= '0;
			header_eid <= '0;
			is_fragment <= 1'b0;
			header_done <= 1'b0;
			overflow <= 1'b0;
		end else begin
			overflow <= 1'b0;
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case (state)
			hd_idle: begin
				if (ma_frame_valid) begin
					wr_ptr <= '0;                  // fresh fifo for each accepted frame
					rd_ptr <= '0;
					if (ma_data_valid) begin
						header_eid <= ma_data;     // eid may come with the first cycle
						state <= hd_get_flags;
					end else begin
						state <= hd_get_eid;
					end
				end
			end
			hd_get_eid: begin
				if (!ma_frame_valid) begin
					state <= hd_idle;              // empty frame, nothing to send
				end else if (ma_data_valid) begin
					header_eid <= ma_data;
					state <= hd_get_flags;
				end
			end
			hd_get_flags: begin
				if (!ma_frame_valid) begin
					state <= hd_idle;              // a lone eid byte is ignored
				end else if (ma_data_valid) begin
					is_fragment <= ma_data[0];
					state <= hd_payload;
				end
			end
			hd_payload: begin
				if (!ma_frame_valid) begin
					header_done <= 1'b1;
					state <= hd_hold;
				end
			end
			hd_hold: begin
				if (tx_done) begin
					header_done <= 1'b0;
					state <= ma_frame_valid ? hd_drop : hd_idle;
				end else if (ma_frame_valid) begin
					state <= hd_drop;              // link still busy with the last frame
				end
			end
			hd_drop: begin
				if (tx_done) begin
					header_done <= 1'b0;
				end
				if (!ma_frame_valid) begin
					overflow <= 1'b1;
					state <= (header_done && !tx_done) ? hd_hold : hd_idle;
				end
			end
			default: state <= hd_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== ein_pkg.sv ====
`default_nettype none

package ein_pkg;

	typedef logic [7:0] byte_t;         // one byte on the master or ack bus
	typedef logic [7:0] eid_t;          // event id carried in the first frame byte
	typedef logic [23:0] div_t;         // symbol period minus one, in clock cycles

	localparam int fifo_depth = 16;     // payload bytes kept per frame
	localparam int fifo_aw = $clog2(fifo_depth);

	typedef logic [fifo_aw:0] ptr_t;    // one extra bit so a full fifo differs from empty

	localparam byte_t ack_code = 8'h06; // first byte of every acknowledge

	typedef enum logic [2:0] {
		hd_idle,
		hd_get_eid,
		hd_get_flags,
		hd_payload,
		hd_hold,                        // frame stored, waiting for the modulator
		hd_drop                         // frame arrived during hold and is discarded
	} hd_state_t;

	typedef enum logic [1:0] {
		mod_idle,
		mod_load,
		mod_symbol,
		mod_end_mark
	} mod_state_t;

	typedef enum logic [1:0] {
		ctl_idle,
		ctl_transmitting,
		ctl_acknowledge
	} ctl_state_t;

endpackage

`default_nettype wire
